/* flist.f */
hw/isaPkg.sv
hw/pipePkg.sv
hw/mainDecoder.sv
hw/regFile.sv
hw/alu.sv
hw/hazardUnit.sv
hw/datapath.sv
sim/tbClock.sv
sim/datapathTb.sv

/* hw/alu.sv */
`default_nettype none

module alu (
    input  var pipePkg::aluOpE         aluOp_i,
    input  wire [isaPkg::XLEN-1:0]     srcA_i,
    input  wire [isaPkg::XLEN-1:0]     srcB_i,
    output logic [isaPkg::XLEN-1:0]    result_o,
    output logic                       equal_o
);

    logic lessThan;

    assign lessThan = $signed(srcA_i) < $signed(srcB_i);

    always_comb begin
        case (aluOp_i)
            pipePkg::ADD: result_o = srcA_i + srcB_i;   // no overflow trap
            pipePkg::SUB: result_o = srcA_i - srcB_i;
            pipePkg::AND: result_o = srcA_i & srcB_i;
            pipePkg::OR:  result_o = srcA_i | srcB_i;
            pipePkg::SLT: result_o = {{(isaPkg::XLEN - 1){1'b0}}, lessThan};
            pipePkg::LUI: begin
                // immediate arrives zero extended in b
                result_o = {srcB_i[isaPkg::IMM_W-1:0], {isaPkg::IMM_W{1'b0}}};
            end
            default:      result_o = '0;
        endcase
    end

    // beq and bne decide on this in execute
    assign equal_o = (srcA_i == srcB_i);

endmodule

`default_nettype wire

/* hw/datapath.sv */
`default_nettype none

module datapath (
    input  wire                        clk,
    input  wire                        rstN_i,
    input  wire                        iStall_i,
    input  wire                        dStall_i,
    input  wire [isaPkg::XLEN-1:0]     instrF_i,
    input  wire [isaPkg::XLEN-1:0]     memRdataM_i,
    output logic [isaPkg::XLEN-1:0]    pcF_o,
    output logic                       instEnF_o,
    output logic                       memEnM_o,
    output logic                       memWeM_o,
    output logic [isaPkg::XLEN-1:0]    memAddrM_o,
    output logic [isaPkg::XLEN-1:0]    memWdataM_o,
    output logic [isaPkg::XLEN-1:0]    debugWbPc_o,
    output logic [3:0]                 debugWbRfWen_o,
    output logic [isaPkg::REG_AW-1:0]  debugWbRfWnum_o,
    output logic [isaPkg::XLEN-1:0]    debugWbRfWdata_o
);

    logic                         fetchOn;    // low until the first edge after reset
    logic [isaPkg::XLEN-1:0]      pcPlus4F, pcNext;

    logic [isaPkg::XLEN-1:0]      instrD, pcD, rd1D, rd2D, immD;
    logic [isaPkg::REG_AW-1:0]    rsD, rtD, writeRegD;
    pipePkg::aluOpE               aluSelD;
    logic                         signExtD, useImmD, regWriteD;
    logic                         memReadD, memWriteD, branchD, branchNeD;

    logic [isaPkg::XLEN-1:0]      pcE, rd1E, rd2E, immE;
    logic [isaPkg::REG_AW-1:0]    rsE, rtE, writeRegE;
    pipePkg::aluOpE               aluSelE;
    logic                         useImmE, regWriteE, memReadE, memWriteE, branchE, branchNeE;
    pipePkg::fwdSelE              fwdA, fwdB;
    logic [isaPkg::XLEN-1:0]      srcAE, rtValE, srcBE, aluOutE, branchTargetE;
    logic                         equalE, branchTakenE;

    logic [isaPkg::XLEN-1:0]      pcM, aluOutM;
    logic [isaPkg::REG_AW-1:0]    writeRegM;
    logic                         regWriteM, memReadM;

    logic [isaPkg::XLEN-1:0]      pcW, aluOutW, readDataW, resultW;
    logic [isaPkg::REG_AW-1:0]    writeRegW;
    logic                         regWriteW, memToRegW, rfWe;

    logic                         stallF, stallD, freeze, flushD, flushE;

    function automatic logic [isaPkg::XLEN-1:0] fwdMux(
        input pipePkg::fwdSelE         sel,
        input logic [isaPkg::XLEN-1:0] rfVal,
        input logic [isaPkg::XLEN-1:0] memVal,
        input logic [isaPkg::XLEN-1:0] wbVal
    );
        case (sel)
            pipePkg::FWD_MEM: return memVal;
            pipePkg::FWD_WB:  return wbVal;
            default:          return rfVal;
        endcase
    endfunction

    assign pcPlus4F  = pcF_o + 32'd4;
    assign pcNext    = branchTakenE ? branchTargetE : pcPlus4F;    // redirect from execute
    assign instEnF_o = fetchOn;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            fetchOn <= 1'b0;
            pcF_o   <= isaPkg::RESET_PC;
        end else if (!freeze) begin
            fetchOn <= 1'b1;
            if (fetchOn && !stallF) begin
                pcF_o <= pcNext;
            end
        end
    end

    // decode register, an all-zero word is a nop
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            instrD <= '0;
        end else if (!freeze && !stallD) begin
            instrD <= (flushD || !fetchOn) ? '0 : instrF_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && !stallD) begin
            pcD <= pcF_o;
        end
    end

    assign rsD  = instrD[25:21];
    assign rtD  = instrD[20:16];
    assign immD = signExtD
                ? {{(isaPkg::XLEN - isaPkg::IMM_W){instrD[isaPkg::IMM_W-1]}},
                   instrD[isaPkg::IMM_W-1:0]}
                : {{(isaPkg::XLEN - isaPkg::IMM_W){1'b0}}, instrD[isaPkg::IMM_W-1:0]};

    mainDecoder decoder (
        .instr_i    (instrD),
        .aluOp_o    (aluSelD),
        .signExt_o  (signExtD),
        .useImm_o   (useImmD),
        .regWrite_o (regWriteD),
        .writeReg_o (writeRegD),
        .memRead_o  (memReadD),
        .memWrite_o (memWriteD),
        .branch_o   (branchD),
        .branchNe_o (branchNeD)
    );

    regFile rf (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .we_i     (rfWe),
        .waddr_i  (writeRegW),
        .wdata_i  (resultW),
        .raddr1_i (rsD),
        .raddr2_i (rtD),
        .rdata1_o (rd1D),
        .rdata2_o (rd2D)
    );

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regWriteE <= 1'b0;
            memReadE  <= 1'b0;
            memWriteE <= 1'b0;
            branchE   <= 1'b0;
        end else if (!freeze) begin
            regWriteE <= regWriteD && !flushE;
            memReadE  <= memReadD && !flushE;
            memWriteE <= memWriteD && !flushE;
            branchE   <= branchD && !flushE;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            pcE       <= pcD;
            rd1E      <= rd1D;
            rd2E      <= rd2D;
            immE      <= immD;
            rsE       <= rsD;
            rtE       <= rtD;
            writeRegE <= writeRegD;
            aluSelE   <= aluSelD;
            useImmE   <= useImmD;
            branchNeE <= branchNeD;
        end
    end

    assign srcAE  = fwdMux(fwdA, rd1E, aluOutM, resultW);
    assign rtValE = fwdMux(fwdB, rd2E, aluOutM, resultW);   // also the store data
    assign srcBE  = useImmE ? immE : rtValE;

    alu alu0 (
        .aluOp_i  (aluSelE),
        .srcA_i   (srcAE),
        .srcB_i   (srcBE),
        .result_o (aluOutE),
        .equal_o  (equalE)
    );

    assign branchTakenE  = branchE && (equalE != branchNeE);
    assign branchTargetE = pcE + 32'd4 + {immE[isaPkg::XLEN-3:0], 2'b00};  // from delay slot

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regWriteM <= 1'b0;
            memReadM  <= 1'b0;
            memEnM_o  <= 1'b0;
            memWeM_o  <= 1'b0;
        end else if (!freeze) begin
            regWriteM <= regWriteE;
            memReadM  <= memReadE;
            memEnM_o  <= memReadE || memWriteE;
            memWeM_o  <= memWriteE;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            pcM         <= pcE;
            aluOutM     <= aluOutE;
            memWdataM_o <= rtValE;
            writeRegM   <= writeRegE;
        end
    end

    assign memAddrM_o = aluOutM;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
        end else if (!freeze) begin
            regWriteW <= regWriteM;
            memToRegW <= memReadM;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            pcW       <= pcM;
            aluOutW   <= aluOutM;
            readDataW <= memRdataM_i;
            writeRegW <= writeRegM;
        end
    end

    assign resultW = memToRegW ? readDataW : aluOutW;
    assign rfWe    = regWriteW && !freeze;  // no retire while frozen

    assign debugWbPc_o      = pcW;
    assign debugWbRfWen_o   = {4{rfWe}};
    assign debugWbRfWnum_o  = writeRegW;
    assign debugWbRfWdata_o = resultW;

    hazardUnit hazard (
        .iStall_i       (iStall_i),
        .dStall_i       (dStall_i),
        .rsD_i          (rsD),
        .rtD_i          (rtD),
        .rsE_i          (rsE),
        .rtE_i          (rtE),
        .memReadE_i     (memReadE),
        .writeRegE_i    (writeRegE),
        .regWriteM_i    (regWriteM),
        .writeRegM_i    (writeRegM),
        .regWriteW_i    (regWriteW),
        .writeRegW_i    (writeRegW),
        .branchTakenE_i (branchTakenE),
        .stallF_o       (stallF),
        .stallD_o       (stallD),
        .freeze_o       (freeze),
        .flushD_o       (flushD),
        .flushE_o       (flushE),
        .fwdA_o         (fwdA),
        .fwdB_o         (fwdB)
    );

    // enable and write strobe come from separate execute decodes
    assert property (@(posedge clk) disable iff (!rstN_i) memWeM_o |-> memEnM_o)
        else $error("datapath: memory write strobe without memory enable");

endmodule

`default_nettype wire

/* hw/hazardUnit.sv */
`default_nettype none

module hazardUnit (
    input  wire                        iStall_i,
    input  wire                        dStall_i,
    input  wire [isaPkg::REG_AW-1:0]   rsD_i,
    input  wire [isaPkg::REG_AW-1:0]   rtD_i,
    input  wire [isaPkg::REG_AW-1:0]   rsE_i,
    input  wire [isaPkg::REG_AW-1:0]   rtE_i,
    input  wire                        memReadE_i,
    input  wire [isaPkg::REG_AW-1:0]   writeRegE_i,
    input  wire                        regWriteM_i,
    input  wire [isaPkg::REG_AW-1:0]   writeRegM_i,
    input  wire                        regWriteW_i,
    input  wire [isaPkg::REG_AW-1:0]   writeRegW_i,
    input  wire                        branchTakenE_i,
    output logic                       stallF_o,
    output logic                       stallD_o,
    output logic                       freeze_o,
    output logic                       flushD_o,
    output logic                       flushE_o,
    output pipePkg::fwdSelE            fwdA_o,
    output pipePkg::fwdSelE            fwdB_o
);

    logic loadUse;

    function automatic pipePkg::fwdSelE fwdFor(
        input logic [isaPkg::REG_AW-1:0] src,
        input logic                      wenM,
        input logic [isaPkg::REG_AW-1:0] dstM,
        input logic                      wenW,
        input logic [isaPkg::REG_AW-1:0] dstW
    );
        if (wenM && dstM == src) begin
            return pipePkg::FWD_MEM;    // youngest producer wins
        end
        if (wenW && dstW == src) begin
            return pipePkg::FWD_WB;
        end
        return pipePkg::FWD_RF;
    endfunction

    // either cache stalling holds every stage
    assign freeze_o = iStall_i | dStall_i;

    // load data only exists after memory, so the consumer waits a cycle
    assign loadUse = memReadE_i && (writeRegE_i != '0)
                  && (writeRegE_i == rsD_i || writeRegE_i == rtD_i);

    assign stallF_o = loadUse;
    assign stallD_o = loadUse;
    assign flushE_o = loadUse && !freeze_o;     // bubble into execute
    assign flushD_o = branchTakenE_i && !freeze_o;  // squash fetch behind delay slot

    assign fwdA_o = fwdFor(rsE_i, regWriteM_i, writeRegM_i, regWriteW_i, writeRegW_i);
    assign fwdB_o = fwdFor(rtE_i, regWriteM_i, writeRegM_i, regWriteW_i, writeRegW_i);

    // a branch in execute is never a load, so it cannot meet a load-use stall
    flushVsStall: assert final (!(flushD_o && stallD_o))
        else $error("hazardUnit: decode flushed and stalled in the same cycle");

endmodule

`default_nettype wire

/* hw/isaPkg.sv */
`default_nettype none

package isaPkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;
    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int IMM_W    = 16;

    // first fetch, boot rom in kseg1
    localparam logic [XLEN-1:0] RESET_PC = 32'hbfc0_0000;

    // major opcode, instr[31:26]
    typedef enum logic [OPCODE_W-1:0] {
        SPECIAL = 6'b000000,    // r-type, see funct
        BEQ     = 6'b000100,
        BNE     = 6'b000101,
        ADDIU   = 6'b001001,
        ORI     = 6'b001101,
        LUI     = 6'b001111,
        LW      = 6'b100011,
        SW      = 6'b101011
    } opcodeE;

    // funct field of SPECIAL, instr[5:0]
    typedef enum logic [FUNCT_W-1:0] {
        ADDU = 6'b100001,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        SLT  = 6'b101010
    } functE;

endpackage

`default_nettype wire

/* hw/mainDecoder.sv */
`default_nettype none

module mainDecoder (
    input  wire [isaPkg::XLEN-1:0]     instr_i,
    output pipePkg::aluOpE             aluOp_o,
    output logic                       signExt_o,
    output logic                       useImm_o,
    output logic                       regWrite_o,
    output logic [isaPkg::REG_AW-1:0]  writeReg_o,
    output logic                       memRead_o,
    output logic                       memWrite_o,
    output logic                       branch_o,
    output logic                       branchNe_o
);

    isaPkg::opcodeE opcode;
    isaPkg::functE  funct;
    logic           destRd;     // r-type writes rd, the rest rt

    assign opcode = isaPkg::opcodeE'(instr_i[31:26]);
    assign funct  = isaPkg::functE'(instr_i[5:0]);

    always_comb begin
        aluOp_o    = pipePkg::ADD;
        signExt_o  = 1'b0;
        useImm_o   = 1'b0;
        regWrite_o = 1'b0;
        memRead_o  = 1'b0;
        memWrite_o = 1'b0;
        branch_o   = 1'b0;
        branchNe_o = 1'b0;
        destRd     = 1'b0;
        case (opcode)
            isaPkg::SPECIAL: begin
                destRd     = 1'b1;
                regWrite_o = 1'b1;
                case (funct)
                    isaPkg::ADDU: aluOp_o = pipePkg::ADD;
                    isaPkg::SUBU: aluOp_o = pipePkg::SUB;
                    isaPkg::AND:  aluOp_o = pipePkg::AND;
                    isaPkg::OR:   aluOp_o = pipePkg::OR;
                    isaPkg::SLT:  aluOp_o = pipePkg::SLT;
                    default:      regWrite_o = 1'b0;    // nop and unsupported
                endcase
            end
            isaPkg::ADDIU: begin
                signExt_o  = 1'b1;
                useImm_o   = 1'b1;
                regWrite_o = 1'b1;
            end
            isaPkg::ORI: begin
                aluOp_o    = pipePkg::OR;
                useImm_o   = 1'b1;
                regWrite_o = 1'b1;
            end
            isaPkg::LUI: begin
                aluOp_o    = pipePkg::LUI;
                useImm_o   = 1'b1;
                regWrite_o = 1'b1;
            end
            isaPkg::LW: begin
                signExt_o  = 1'b1;
                useImm_o   = 1'b1;
                regWrite_o = 1'b1;
                memRead_o  = 1'b1;
            end
            isaPkg::SW: begin
                signExt_o  = 1'b1;
                useImm_o   = 1'b1;
                memWrite_o = 1'b1;
            end
            isaPkg::BEQ, isaPkg::BNE: begin
                // offset is signed, compare uses both registers
                aluOp_o    = pipePkg::SUB;
                signExt_o  = 1'b1;
                branch_o   = 1'b1;
                branchNe_o = (opcode == isaPkg::BNE);
            end
            default: ;
        endcase
        writeReg_o = destRd ? instr_i[15:11] : instr_i[20:16];
        if (writeReg_o == '0) begin
            regWrite_o = 1'b0;  // $zero stays zero
        end
    end

endmodule

`default_nettype wire

/* hw/pipePkg.sv */
`default_nettype none

package pipePkg;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        SLT,
        LUI     // operand b into the upper half
    } aluOpE;

    // source of one execute operand
    typedef enum logic [1:0] {
        FWD_RF  = 2'b00,
        FWD_MEM = 2'b01,    // alu result sitting in memory stage
        FWD_WB  = 2'b10
    } fwdSelE;

    // fetches squashed behind a taken branch
    localparam int BRANCH_PENALTY = 1;

endpackage

`default_nettype wire

/* hw/regFile.sv */
`default_nettype none

module regFile (
    input  wire                        clk,
    input  wire                        rstN_i,
    input  wire                        we_i,
    input  wire [isaPkg::REG_AW-1:0]   waddr_i,
    input  wire [isaPkg::XLEN-1:0]     wdata_i,
    input  wire [isaPkg::REG_AW-1:0]   raddr1_i,
    input  wire [isaPkg::REG_AW-1:0]   raddr2_i,
    output logic [isaPkg::XLEN-1:0]    rdata1_o,
    output logic [isaPkg::XLEN-1:0]    rdata2_o
);

    logic [isaPkg::XLEN-1:0] regs [isaPkg::NUM_REGS];

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < isaPkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // writeback value bypasses to decode in the same cycle
    assign rdata1_o = (raddr1_i == '0) ? '0
                    : (we_i && raddr1_i == waddr_i) ? wdata_i
                    : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0
                    : (we_i && raddr2_i == waddr_i) ? wdata_i
                    : regs[raddr2_i];

    // decoder must have dropped any write to $zero before writeback
    assert property (@(posedge clk) disable iff (!rstN_i) we_i |-> waddr_i != '0)
        else $error("regFile: write enable with destination register zero");

endmodule

`default_nettype wire

/* sim/datapathTb.sv */
`default_nettype none

module datapathTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_WORDS = 64;    // program, expected writes and data memory

    logic        clk;
    logic        rstN;
    logic        resetReq = 1'b0;
    logic        iStall = 1'b0;
    logic        dStall = 1'b0;
    logic [31:0] instrF, memRdata, pcF, memAddr, memWdata, wbPc, wbData;
    logic        instEn, memEn, memWe;
    logic [3:0]  wbWen;
    logic [4:0]  wbNum;

    logic [31:0] prog [MAX_WORDS];
    logic [31:0] dmem [MAX_WORDS];
    logic [31:0] modelMem [MAX_WORDS];    // data memory as the interpreter leaves it
    logic [31:0] expPcA [MAX_WORDS];
    logic [4:0]  expNumA [MAX_WORDS];
    logic [31:0] expDataA [MAX_WORDS];
    int          progLen = 0;
    int          expCount = 0;
    int          memStart;
    int          branchStart;
    int          retireIdx = 0;
    int          passNum = 1;
    logic        built = 1'b0;
    logic        stallOn = 1'b0;
    logic        armed = 1'b0;
    logic        rstSeen = 1'b0;
    logic [31:0] lcgState = 32'hb30d;
    int          errCount [5] = '{default: 0};
    string       testName [5] = '{"reset", "alu chain", "store-load",
                                   "branches", "random stalls"};
    logic        retiring, inRange;
    logic [31:0] expPc, expData, fetchIdx;
    logic [4:0]  expNum;

    tbClock clkGen (.resetReq_i(resetReq), .clk_o(clk), .rstN_o(rstN));

    datapath uut (
        .clk              (clk),
        .rstN_i           (rstN),
        .iStall_i         (iStall),
        .dStall_i         (dStall),
        .instrF_i         (instrF),
        .memRdataM_i      (memRdata),
        .pcF_o            (pcF),
        .instEnF_o        (instEn),
        .memEnM_o         (memEn),
        .memWeM_o         (memWe),
        .memAddrM_o       (memAddr),
        .memWdataM_o      (memWdata),
        .debugWbPc_o      (wbPc),
        .debugWbRfWen_o   (wbWen),
        .debugWbRfWnum_o  (wbNum),
        .debugWbRfWdata_o (wbData)
    );

    assign fetchIdx = (pcF - isaPkg::RESET_PC) >> 2;
    // nops past the end and while fetch is off
    assign instrF   = (instEn && fetchIdx < progLen) ? prog[fetchIdx] : 32'h0;
    assign memRdata = dmem[memAddr[7:2]];

    always @(posedge clk) begin
        if (memEn && memWe && !dStall) begin
            dmem[memAddr[7:2]] <= memWdata;
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] fillWord(input int idx);
        logic [15:0] addr;
        addr = 16'(idx * 4);
        return {~addr, addr};    // whole byte address in both halves
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input int rd, rs, rt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input int rt, rs, imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic int testOf(input logic [31:0] pc);
        int idx;
        idx = int'((pc - isaPkg::RESET_PC) >> 2);
        if (passNum == 2) begin
            return 4;
        end
        if (idx >= branchStart) begin
            return 3;
        end
        return (idx >= memStart) ? 2 : 1;
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic fillDataMem();
        for (int i = 0; i < MAX_WORDS; i++) begin
            dmem[i] <= fillWord(i);
        end
    endtask

    task automatic buildProgram();
        emit(iType(isaPkg::LUI, 1, 0, 'h1234));    // back to back, so mem and wb forwarding
        emit(iType(isaPkg::ORI, 1, 1, 'h5678));
        emit(iType(isaPkg::ADDIU, 2, 1, -8));
        emit(rType(isaPkg::ADDU, 3, 1, 2));
        emit(rType(isaPkg::SUBU, 4, 3, 1));
        emit(rType(isaPkg::AND, 5, 4, 3));
        emit(rType(isaPkg::OR, 6, 5, 1));
        emit(rType(isaPkg::SLT, 7, 4, 1));
        emit(iType(isaPkg::ADDIU, 8, 0, -5));
        emit(rType(isaPkg::SLT, 9, 8, 7));    // negative against positive
        emit(rType(isaPkg::SLT, 10, 7, 8));
        memStart = progLen;
        emit(iType(isaPkg::SW, 6, 0, 'h40));
        emit(iType(isaPkg::LW, 11, 0, 'h40));
        emit(rType(isaPkg::ADDU, 12, 11, 1));    // load-use
        emit(iType(isaPkg::SW, 12, 0, 'h44));
        emit(iType(isaPkg::LW, 13, 0, 'h44));
        emit(rType(isaPkg::OR, 14, 13, 13));
        branchStart = progLen;
        emit(iType(isaPkg::BEQ, 6, 11, 2));    // taken
        emit(iType(isaPkg::ADDIU, 15, 0, 1));
        emit(iType(isaPkg::ADDIU, 16, 0, 'h77));    // must never retire
        emit(iType(isaPkg::BNE, 0, 15, 2));    // taken
        emit(iType(isaPkg::ADDIU, 17, 15, 2));
        emit(iType(isaPkg::ADDIU, 16, 0, 'h99));    // must never retire
        emit(iType(isaPkg::BEQ, 17, 15, 2));    // not taken
        emit(iType(isaPkg::ADDIU, 18, 17, 3));
        emit(iType(isaPkg::ADDIU, 19, 18, 4));
        emit(iType(isaPkg::BNE, 19, 19, 2));    // not taken
        emit(iType(isaPkg::ADDIU, 20, 19, 5));
        emit(rType(isaPkg::ADDU, 21, 20, 18));
        emit(iType(isaPkg::SW, 21, 0, 'h48));
        emit(iType(isaPkg::ADDIU, 22, 21, 1));    // last write lands after every store
    endtask

    // in-order reference with one delay slot per branch
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] pc, npc, next, w, a, b, simm, addr, val;
        logic [4:0]  dst;
        regs = '{default: 32'h0};
        for (int i = 0; i < MAX_WORDS; i++) begin
            modelMem[i] = fillWord(i);
        end
        pc  = isaPkg::RESET_PC;
        npc = pc + 32'd4;
        while (((pc - isaPkg::RESET_PC) >> 2) < progLen) begin
            w    = prog[(pc - isaPkg::RESET_PC) >> 2];
            a    = regs[w[25:21]];
            b    = regs[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            addr = a + simm;
            dst  = w[20:16];    // rt unless r-type
            val  = '0;
            next = npc + 32'd4;
            case (w[31:26])
                isaPkg::SPECIAL: begin
                    dst = w[15:11];
                    case (w[5:0])
                        isaPkg::ADDU: val = a + b;
                        isaPkg::SUBU: val = a - b;
                        isaPkg::AND:  val = a & b;
                        isaPkg::OR:   val = a | b;
                        isaPkg::SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:      dst = '0;
                    endcase
                end
                isaPkg::ADDIU: val = addr;
                isaPkg::ORI:   val = a | {16'h0, w[15:0]};
                isaPkg::LUI:   val = {w[15:0], 16'h0};
                isaPkg::LW:    val = modelMem[addr[7:2]];
                isaPkg::SW: begin
                    modelMem[addr[7:2]] = b;
                    dst = '0;
                end
                isaPkg::BEQ, isaPkg::BNE: begin
                    dst = '0;
                    if ((a == b) == (w[31:26] == isaPkg::BEQ)) begin
                        next = pc + 32'd4 + (simm << 2);
                    end
                end
                default: dst = '0;
            endcase
            if (dst != '0) begin
                expPcA[expCount]   = pc;
                expNumA[expCount]  = dst;
                expDataA[expCount] = val;
                regs[dst]          = val;
                expCount++;
            end
            pc  = npc;
            npc = next;
        end
    endtask

    task automatic wrongValue(input int t, input string what, input logic [31:0] exp, act);
        errCount[t]++;
        $display("[ERROR] %s: %s expected %0h actual %0h", testName[t], what, exp, act);
    endtask

    task automatic checkDataMem(input int t);
        for (int i = 0; i < MAX_WORDS; i++) begin
            assert (dmem[i] == modelMem[i])
                else wrongValue(t, $sformatf("data word %0d", i), modelMem[i], dmem[i]);
        end
    endtask

    task automatic reportTest(input int t);
        if (errCount[t] == 0) begin
            $display("test %-13s ok", testName[t]);
        end else begin
            $display("test %-13s %0d error(s)", testName[t], errCount[t]);
        end
    endtask

    assign retiring = (wbWen == 4'hf);
    assign inRange  = (retireIdx < expCount);
    assign expPc    = inRange ? expPcA[retireIdx] : '0;
    assign expNum   = inRange ? expNumA[retireIdx] : '0;
    assign expData  = inRange ? expDataA[retireIdx] : '0;

    always @(posedge clk) begin
        armed   <= 1'b1;
        rstSeen <= rstN;
        if (!rstN) begin
            retireIdx <= 0;
        end else if (retiring) begin
            retireIdx <= retireIdx + 1;
        end
    end

    always @(posedge clk) begin
        if (stallOn) begin
            lcgState <= lcgNext(lcgState);
            iStall   <= (lcgState[31:30] == 2'b00);    // roughly one cycle in four
            dStall   <= (lcgState[29:28] == 2'b00);
        end else begin
            iStall <= 1'b0;
            dStall <= 1'b0;
        end
    end

    // reset and the first cycle after it
    resetPc: assert property (@(posedge clk) armed && !(rstN && rstSeen)
                              |-> pcF == isaPkg::RESET_PC)
        else wrongValue((passNum == 2) ? 4 : 0, "pcF_o", isaPkg::RESET_PC, $sampled(pcF));
    resetStrobes: assert property (@(posedge clk) armed && !(rstN && rstSeen)
                                   |-> wbWen == 4'h0 && !memEn)
        else wrongValue((passNum == 2) ? 4 : 0, "debug wen and memory enable", 32'h0,
                        {$sampled(wbWen), $sampled(memEn)});
    // fetch enable and write strobe while reset is held
    resetFetch: assert property (@(posedge clk) armed && !rstN |-> !instEn && !memWe)
        else wrongValue((passNum == 2) ? 4 : 0, "fetch enable and write strobe", 32'h0,
                        {$sampled(instEn), $sampled(memWe)});

    retirePc: assert property (@(posedge clk) disable iff (!rstN)
                               retiring && inRange |-> wbPc == expPc)
        else wrongValue(testOf($sampled(expPc)), "retired pc", $sampled(expPc), $sampled(wbPc));
    retireNum: assert property (@(posedge clk) disable iff (!rstN)
                                retiring && inRange |-> wbNum == expNum)
        else wrongValue(testOf($sampled(expPc)), "register number",
                        $sampled(expNum), $sampled(wbNum));
    retireData: assert property (@(posedge clk) disable iff (!rstN)
                                 retiring && inRange |-> wbData == expData)
        else wrongValue(testOf($sampled(expPc)), "register data",
                        $sampled(expData), $sampled(wbData));
    retireCount: assert property (@(posedge clk) disable iff (!rstN) retiring |-> inRange)
        else begin
            errCount[testOf($sampled(wbPc))]++;
            $display("the DUT wrote a register after the last write the program makes");
        end

    initial begin
        int limit;
        wait (built);
        limit = progLen * (1 + pipePkg::BRANCH_PENALTY) * 4 + 200;
        repeat (limit) @(posedge clk);
        $display("timeout: the program did not finish within %0d cycles", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int okTests;
        int errTotal;
        buildProgram();
        runModel();
        built = 1'b1;
        fillDataMem();
        wait (rstN);
        repeat (2) @(posedge clk);
        reportTest(0);
        wait (retireIdx == expCount);
        repeat (8) @(posedge clk);    // room for a stray extra write
        checkDataMem(2);
        reportTest(1);
        reportTest(2);
        reportTest(3);

        // same program again under random cache stalls
        passNum = 2;
        resetReq <= 1'b1;
        @(posedge clk);
        resetReq <= 1'b0;
        stallOn  <= 1'b1;
        @(posedge clk);
        fillDataMem();
        wait (rstN);
        wait (retireIdx == expCount);
        repeat (8) @(posedge clk);
        checkDataMem(4);
        reportTest(4);

        okTests  = 0;
        errTotal = 0;
        for (int t = 0; t < 5; t++) begin
            errTotal += errCount[t];
            if (errCount[t] == 0) begin
                okTests++;
            end
        end
        $display("%0d of 5 tests ok, %0d error(s)", okTests, errTotal);
        if (errTotal == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tbClock.sv */
`default_nettype none

module tbClock (
    input  wire  resetReq_i,
    output logic clk_o,
    output logic rstN_o
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [2:0] holdCnt = 3'd5;    // rising edges left in reset

    initial begin
        clk_o  = 1'b0;
        rstN_o = 1'b0;
        forever #5 clk_o = ~clk_o;    // 10 ns period
    end

    // reset again on request, for the same five edges
    always @(posedge clk_o) begin
        if (resetReq_i) begin
            rstN_o  <= 1'b0;
            holdCnt <= 3'd5;
        end else if (holdCnt != 3'd0) begin
            holdCnt <= holdCnt - 3'd1;
            rstN_o  <= (holdCnt == 3'd1);
        end
    end

endmodule

`default_nettype wire
